// File: logic/fp_pkg.sv
package fp_pkg;

    localparam int fp_exp_w  = 8;
    localparam int fp_mant_w = 7;
    localparam int fp_width  = 1 + fp_exp_w + fp_mant_w;
    localparam int fp_bias   = 127;

    typedef struct packed {
        logic                 sign;
        logic [fp_exp_w-1:0]  exp;
        logic [fp_mant_w-1:0] mant;
    } fp_fields_t;

    typedef union packed {
        logic [fp_width-1:0] bits;
        fp_fields_t          f;
    } fp_word_u;

    // requester tags.
    typedef logic req_id_t;
    localparam req_id_t req_exp   = 1'b0;
    localparam req_id_t req_scale = 1'b1;

    // cubic coefficients and shifts for the exp polynomial.
    localparam int poly_c3  = 1277;
    localparam int poly_c2  = 14825;
    localparam int poly_c1  = 79749;
    localparam int poly_c0  = 626;
    localparam int poly_sh3 = 14;
    localparam int poly_sh2 = 14;
    localparam int poly_sh1 = 11;

    function automatic fp_word_u int_to_fp(input longint x);
        fp_word_u    w;
        logic [63:0] mag;
        int          lead;
        w.bits = '0;
        mag = (x < 0) ? 64'(-x) : 64'(x);
        lead = -1;
        for (int i = 0; i < 64; i++) begin
            if (mag[i]) lead = i;             // keeps the highest set bit.
        end
        if (lead >= 0) begin
            mag = mag << (63 - lead);         // leading one to bit 63.
            w.f.sign = (x < 0);
            w.f.exp = fp_exp_w'(fp_bias + lead);
            w.f.mant = mag[62 -: fp_mant_w];  // truncated.
        end
        return w;
    endfunction

    localparam fp_word_u exp_log2e_const = int_to_fp(64'sd6196328019);

endpackage

// File: logic/mlt_if.sv
`timescale 1ns/1ns

interface mlt_if;

    logic             req;        // held until granted.
    fp_pkg::fp_word_u a_word;
    fp_pkg::fp_word_u b_word;
    logic             grant;
    logic             res_valid;  // one cycle pulse.
    fp_pkg::fp_word_u res_word;

    modport requester (
        output req,
        output a_word,
        output b_word,
        input  grant,
        input  res_valid,
        input  res_word
    );

    modport arbiter (
        input  req,
        input  a_word,
        input  b_word,
        output grant,
        output res_valid,
        output res_word
    );

endinterface

// File: logic/fp_mlt.sv
`timescale 1ns/1ns

module fp_mlt (
    input  logic              clock,
    input  logic              arst_n,
    input  logic              in_valid,
    input  fp_pkg::req_id_t   in_tag,
    input  fp_pkg::fp_word_u  in_a,
    input  fp_pkg::fp_word_u  in_b,
    output logic              out_valid,
    output fp_pkg::req_id_t   out_tag,
    output fp_pkg::fp_word_u  out_word
);

    localparam int prod_w = 2 * (fp_pkg::fp_mant_w + 1);

    logic                    s1_valid;
    fp_pkg::req_id_t         s1_tag;
    logic                    s1_sign;
    logic signed [10:0]      s1_exp;
    logic [prod_w-1:0]       s1_prod;
    logic                    s1_zero;

    logic signed [10:0]      norm_exp;
    logic [fp_pkg::fp_mant_w-1:0] norm_mant;
    fp_pkg::fp_word_u        res;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage one: sign, exponent sum, product
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
            out_valid <= s1_valid;
        end
    end

    always_ff @(posedge clock) begin
        s1_tag <= in_tag;
        s1_sign <= in_a.f.sign ^ in_b.f.sign;
        s1_exp <= 11'(in_a.f.exp) + 11'(in_b.f.exp) - 11'(fp_pkg::fp_bias);
        s1_prod <= {1'b1, in_a.f.mant} * {1'b1, in_b.f.mant};  // hidden ones.
        s1_zero <= (in_a.f.exp == '0) || (in_b.f.exp == '0);
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage two: normalize and range checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        if (s1_prod[prod_w-1]) begin
            norm_exp = s1_exp + 11'sd1;
            norm_mant = s1_prod[prod_w-2 -: fp_pkg::fp_mant_w];
        end else begin
            norm_exp = s1_exp;
            norm_mant = s1_prod[prod_w-3 -: fp_pkg::fp_mant_w];
        end
        res.f.sign = s1_sign;
        res.f.exp = norm_exp[fp_pkg::fp_exp_w-1:0];
        res.f.mant = norm_mant;                          // truncated.
        if (s1_zero || norm_exp <= 11'sd0) begin
            res.bits = '0;                               // zero and underflow.
        end else if (norm_exp >= 11'sd255) begin
            res.f.exp = '1;                              // saturate to infinity.
            res.f.mant = '0;
        end
    end

    always_ff @(posedge clock) begin
        out_tag <= s1_tag;
        out_word <= res;
    end

    assert property (@(posedge clock) disable iff (!arst_n) in_valid |-> ##2 out_valid)
        else $error("multiplier result did not appear two cycles after issue");

endmodule

// File: logic/mlt_arbiter.sv
`timescale 1ns/1ns

module mlt_arbiter (
    input  logic              clock,
    input  logic              arst_n,
    mlt_if.arbiter            exp_port,
    mlt_if.arbiter            scale_port,
    output logic              in_valid,
    output fp_pkg::req_id_t   in_tag,
    output fp_pkg::fp_word_u  in_a,
    output fp_pkg::fp_word_u  in_b,
    input  logic              out_valid,
    input  fp_pkg::req_id_t   out_tag,
    input  fp_pkg::fp_word_u  out_word
);

    fp_pkg::req_id_t last_winner;
    logic            both_req;
    logic            pick_scale;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // issue side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign both_req = exp_port.req && scale_port.req;

    // on a tie the peer that did not win last time goes.
    assign pick_scale = both_req ? (last_winner == fp_pkg::req_exp) : scale_port.req;

    assign exp_port.grant = exp_port.req && !pick_scale;
    assign scale_port.grant = scale_port.req && pick_scale;

    assign in_valid = exp_port.req || scale_port.req;
    assign in_tag = pick_scale ? fp_pkg::req_scale : fp_pkg::req_exp;
    assign in_a = pick_scale ? scale_port.a_word : exp_port.a_word;
    assign in_b = pick_scale ? scale_port.b_word : exp_port.b_word;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            last_winner <= fp_pkg::req_scale;   // exp wins the first tie.
        end else if (in_valid) begin
            last_winner <= in_tag;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // return side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign exp_port.res_valid = out_valid && (out_tag == fp_pkg::req_exp);
    assign scale_port.res_valid = out_valid && (out_tag == fp_pkg::req_scale);
    assign exp_port.res_word = out_word;
    assign scale_port.res_word = out_word;

    assert property (@(posedge clock) disable iff (!arst_n)
        !(exp_port.grant && scale_port.grant))
        else $error("both peers granted in one cycle");

endmodule

// File: logic/fp_exp.sv
`timescale 1ns/1ns

module fp_exp #(
    parameter int queue_depth = 4
) (
    input  logic              clock,
    input  logic              arst_n,
    input  logic              data_valid,
    input  fp_pkg::fp_word_u  data,
    output logic              full,
    mlt_if.requester          mlt,
    output logic              result_valid,
    output logic [31:0]       result
);

    localparam int ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;
    localparam int cnt_w = $clog2(queue_depth + 1);

    fp_pkg::fp_word_u             queue_mem [queue_depth];
    logic [ptr_w-1:0]             wr_ptr;
    logic [ptr_w-1:0]             rd_ptr;
    logic [cnt_w-1:0]             count;
    logic                         push;
    logic                         pop;

    logic                         prod_valid;
    logic [fp_pkg::fp_mant_w-1:0] prod_mant;
    logic signed [31:0]           m_ext;
    logic signed [31:0]           t3;
    logic signed [31:0]           t2;
    logic signed [31:0]           t1;

    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
        return (p == ptr_w'(queue_depth - 1)) ? '0 : p + 1'b1;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // input queue
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign push = data_valid && !full;
    assign pop = mlt.grant;
    assign full = (count == cnt_w'(queue_depth));

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) wr_ptr <= ptr_inc(wr_ptr);
            if (pop) rd_ptr <= ptr_inc(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (push) queue_mem[wr_ptr] <= data;
    end

    assign mlt.req = (count != '0);
    assign mlt.a_word = queue_mem[rd_ptr];
    assign mlt.b_word = fp_pkg::exp_log2e_const;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // polynomial on the product mantissa
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        m_ext = 32'(prod_mant);
        t3 = ((m_ext * fp_pkg::poly_c3) >>> fp_pkg::poly_sh3) + fp_pkg::poly_c2;
        t2 = ((t3 * m_ext) >>> fp_pkg::poly_sh2) - fp_pkg::poly_c1;
        t1 = ((t2 * m_ext) >>> fp_pkg::poly_sh1) - fp_pkg::poly_c0;  // shifts are arithmetic.
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            prod_valid <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            prod_valid <= mlt.res_valid;
            result_valid <= prod_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (mlt.res_valid) prod_mant <= mlt.res_word.f.mant;
        if (prod_valid) result <= t1;
    end

    assert property (@(posedge clock) disable iff (!arst_n) data_valid |-> !full)
        else $error("exp input strobed while queue full, word dropped");

endmodule

// File: logic/fp_scale.sv
`timescale 1ns/1ns

module fp_scale #(
    parameter int queue_depth = 4
) (
    input  logic              clock,
    input  logic              arst_n,
    input  logic              data_valid,
    input  fp_pkg::fp_word_u  data,
    input  fp_pkg::fp_word_u  factor,
    output logic              full,
    mlt_if.requester          mlt,
    output logic              result_valid,
    output fp_pkg::fp_word_u  result
);

    localparam int ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;
    localparam int cnt_w = $clog2(queue_depth + 1);

    fp_pkg::fp_word_u  data_mem [queue_depth];
    fp_pkg::fp_word_u  factor_mem [queue_depth];   // factor as seen at the strobe.
    logic [ptr_w-1:0]  wr_ptr;
    logic [ptr_w-1:0]  rd_ptr;
    logic [cnt_w-1:0]  count;
    logic              push;
    logic              pop;

    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
        return (p == ptr_w'(queue_depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign push = data_valid && !full;
    assign pop = mlt.grant;
    assign full = (count == cnt_w'(queue_depth));

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) wr_ptr <= ptr_inc(wr_ptr);
            if (pop) rd_ptr <= ptr_inc(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            data_mem[wr_ptr] <= data;
            factor_mem[wr_ptr] <= factor;
        end
    end

    assign mlt.req = (count != '0);
    assign mlt.a_word = data_mem[rd_ptr];
    assign mlt.b_word = factor_mem[rd_ptr];

    // products go straight out, one register deep.
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= mlt.res_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (mlt.res_valid) result <= mlt.res_word;
    end

    assert property (@(posedge clock) disable iff (!arst_n) data_valid |-> !full)
        else $error("scale input strobed while queue full, word dropped");

endmodule

// File: logic/fp_unit_top.sv
`timescale 1ns/1ns

module fp_unit_top #(
    parameter int queue_depth = 4
) (
    input  logic         clock,
    input  logic         arst_n,
    input  logic         exp_valid,
    input  logic [15:0]  exp_data,
    output logic         exp_full,
    output logic         exp_result_valid,
    output logic [31:0]  exp_result,
    input  logic         scale_valid,
    input  logic [15:0]  scale_data,
    input  logic [15:0]  scale_factor,
    output logic         scale_full,
    output logic         scale_result_valid,
    output logic [15:0]  scale_result
);

    logic              mlt_in_valid;
    fp_pkg::req_id_t   mlt_in_tag;
    fp_pkg::fp_word_u  mlt_in_a;
    fp_pkg::fp_word_u  mlt_in_b;
    logic              mlt_out_valid;
    fp_pkg::req_id_t   mlt_out_tag;
    fp_pkg::fp_word_u  mlt_out_word;

    mlt_if exp_mlt ();
    mlt_if scale_mlt ();

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // peers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    fp_exp #(
        .queue_depth  (queue_depth)
    ) u_fp_exp (
        .clock        (clock),
        .arst_n       (arst_n),
        .data_valid   (exp_valid),
        .data         (exp_data),
        .full         (exp_full),
        .mlt          (exp_mlt.requester),
        .result_valid (exp_result_valid),
        .result       (exp_result)
    );

    fp_scale #(
        .queue_depth  (queue_depth)
    ) u_fp_scale (
        .clock        (clock),
        .arst_n       (arst_n),
        .data_valid   (scale_valid),
        .data         (scale_data),
        .factor       (scale_factor),
        .full         (scale_full),
        .mlt          (scale_mlt.requester),
        .result_valid (scale_result_valid),
        .result       (scale_result)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // shared multiplier
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    mlt_arbiter u_mlt_arbiter (
        .clock      (clock),
        .arst_n     (arst_n),
        .exp_port   (exp_mlt.arbiter),
        .scale_port (scale_mlt.arbiter),
        .in_valid   (mlt_in_valid),
        .in_tag     (mlt_in_tag),
        .in_a       (mlt_in_a),
        .in_b       (mlt_in_b),
        .out_valid  (mlt_out_valid),
        .out_tag    (mlt_out_tag),
        .out_word   (mlt_out_word)
    );

    fp_mlt u_fp_mlt (
        .clock     (clock),
        .arst_n    (arst_n),
        .in_valid  (mlt_in_valid),
        .in_tag    (mlt_in_tag),
        .in_a      (mlt_in_a),
        .in_b      (mlt_in_b),
        .out_valid (mlt_out_valid),
        .out_tag   (mlt_out_tag),
        .out_word  (mlt_out_word)
    );

endmodule

// File: dv/fp_unit_model.svh
`ifndef fp_unit_model_svh
`define fp_unit_model_svh

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// truncating multiply reference
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

function automatic fp_pkg::fp_word_u fp_mul_model(input fp_pkg::fp_word_u a,
                                                  input fp_pkg::fp_word_u b);
    fp_pkg::fp_word_u r;
    int               sig;
    int               e;
    r.bits = '0;
    if (a.f.exp == '0 || b.f.exp == '0) begin
        return r;                                  // zero operand gives zero.
    end
    sig = (128 + int'(a.f.mant)) * (128 + int'(b.f.mant));
    e = int'(a.f.exp) + int'(b.f.exp) - fp_pkg::fp_bias;
    if (sig >= 32768) begin
        e = e + 1;
        sig = sig / 2;                             // product in [2, 4).
    end
    r.f.sign = a.f.sign ^ b.f.sign;
    r.f.exp = 8'(e);
    r.f.mant = 7'((sig / 128) % 128);              // drop the hidden one.
    if (e <= 0) begin
        r.bits = '0;
    end else if (e >= 255) begin
        r.f.exp = 8'hff;                           // infinity keeps its sign.
        r.f.mant = 7'h0;
    end
    return r;
endfunction

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cubic on the product mantissa
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

function automatic logic [31:0] exp_poly_model(input logic [6:0] m);
    int mi;
    int t;
    mi = int'(m);
    t = ((mi * fp_pkg::poly_c3) >>> fp_pkg::poly_sh3) + fp_pkg::poly_c2;
    t = ((t * mi) >>> fp_pkg::poly_sh2) - fp_pkg::poly_c1;
    t = ((t * mi) >>> fp_pkg::poly_sh1) - fp_pkg::poly_c0;
    return t;
endfunction

`endif

// File: dv/fp_unit_tb.sv
`timescale 1ns/1ns

module fp_unit_tb;

    `include "fp_unit_model.svh"

    localparam int queue_depth = 1;     // single entry, so bursts reach full.
    localparam int drain_limit = 200;

    logic        clock;
    logic        arst_n;
    logic        exp_valid;
    logic [15:0] exp_data;
    logic        exp_full;
    logic        exp_result_valid;
    logic [31:0] exp_result;
    logic        scale_valid;
    logic [15:0] scale_data;
    logic [15:0] scale_factor;
    logic        scale_full;
    logic        scale_result_valid;
    logic [15:0] scale_result;

    logic [31:0]      exp_q [$];
    fp_pkg::fp_word_u scale_q [$];

    logic reset_window;
    logic timed_out;
    logic exp_full_seen;
    logic scale_full_seen;
    int   inf_seen;
    int   zero_seen;
    int   exp_errors;
    int   scale_errors;
    int   flag_errors;
    int   unexpected_errors;
    int   timeout_errors;
    int   cover_errors;
    int   total_errors;

    fp_unit_top #(
        .queue_depth        (queue_depth)
    ) u_fp_unit_top (
        .clock              (clock),
        .arst_n             (arst_n),
        .exp_valid          (exp_valid),
        .exp_data           (exp_data),
        .exp_full           (exp_full),
        .exp_result_valid   (exp_result_valid),
        .exp_result         (exp_result),
        .scale_valid        (scale_valid),
        .scale_data         (scale_data),
        .scale_factor       (scale_factor),
        .scale_full         (scale_full),
        .scale_result_valid (scale_result_valid),
        .scale_result       (scale_result)
    );

    always #50 clock = ~clock;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_exp(input logic [31:0] got, input logic [31:0] expv);
        if (got !== expv) begin
            $display("Error: exp_result = %h, expected %h", got, expv);
            exp_errors++;
        end
    endtask

    task automatic check_scale(input fp_pkg::fp_word_u got, input fp_pkg::fp_word_u expv);
        if (got.bits !== expv.bits) begin
            $display("Error: scale_result = %h, expected %h", got.bits, expv.bits);
            scale_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic expv);
        if (got !== expv) begin
            $display("Error: %s = %h, expected %h", name, got, expv);
            flag_errors++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // mode 1 zeroes some exponents, mode 2 picks extreme ones.
    function automatic fp_pkg::fp_word_u gen_word(input int mode);
        fp_pkg::fp_word_u w;
        w.bits = 16'($urandom);
        if (mode == 1 && ($urandom % 4) == 0) begin
            w.f.exp = '0;
        end
        if (mode == 2) begin
            w.f.exp = (($urandom % 2) == 0) ? 8'(200 + $urandom % 55) : 8'(1 + $urandom % 40);
        end
        return w;
    endfunction

    task automatic drive_cycle(input int exp_pct, input int scale_pct, input int mode);
        fp_pkg::fp_word_u a;
        fp_pkg::fp_word_u d;
        fp_pkg::fp_word_u f;
        fp_pkg::fp_word_u p;
        logic             go_exp;
        logic             go_scale;
        @(posedge clock);
        // full seen here is one edge old, so no strobe right after a strobe.
        go_exp = !exp_full && !exp_valid && (($urandom % 100) < exp_pct);
        go_scale = !scale_full && !scale_valid && (($urandom % 100) < scale_pct);
        a = gen_word(mode);
        d = gen_word(mode);
        f = gen_word(mode);
        exp_valid <= go_exp;
        exp_data <= a.bits;
        scale_valid <= go_scale;
        scale_data <= d.bits;
        scale_factor <= f.bits;             // changes every cycle, strobe or not.
        if (go_exp) begin
            p = fp_mul_model(a, fp_pkg::exp_log2e_const);
            exp_q.push_back(exp_poly_model(p.f.mant));
        end
        if (go_scale) begin
            scale_q.push_back(fp_mul_model(d, f));
        end
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while ((exp_q.size() != 0 || scale_q.size() != 0) && n < limit) begin
            @(posedge clock);
            n++;
        end
        if (exp_q.size() != 0 || scale_q.size() != 0) begin
            $display("Timeout: %0d exp and %0d scale results never arrived",
                     exp_q.size(), scale_q.size());
            timeout_errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic run_phase(input int cycles, input int exp_pct, input int scale_pct,
                             input int mode);
        if (timed_out) begin
            return;
        end
        for (int i = 0; i < cycles; i++) begin
            drive_cycle(exp_pct, scale_pct, mode);
        end
        drive_cycle(0, 0, mode);
        wait_drain(drain_limit);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // result monitor
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(negedge clock) begin
        if (exp_full) exp_full_seen = 1'b1;
        if (scale_full) scale_full_seen = 1'b1;
        if (reset_window) begin
            check_flag("exp_full", exp_full, 1'b0);
            check_flag("scale_full", scale_full, 1'b0);
            check_flag("exp_result_valid", exp_result_valid, 1'b0);
            check_flag("scale_result_valid", scale_result_valid, 1'b0);
        end
        if (exp_result_valid) begin
            if (exp_q.size() == 0) begin
                $display("Unexpected exp result with nothing outstanding");
                unexpected_errors++;
            end else begin
                check_exp(exp_result, exp_q.pop_front());
            end
        end
        if (scale_result_valid) begin
            if (scale_result[14:7] == 8'hff && scale_result[6:0] == 7'h0) inf_seen++;
            if (scale_result == 16'h0) zero_seen++;
            if (scale_q.size() == 0) begin
                $display("Unexpected scale result with nothing outstanding");
                unexpected_errors++;
            end else begin
                check_scale(scale_result, scale_q.pop_front());
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        void'($urandom(32'h407a));
        clock = 1'b0;
        arst_n = 1'b0;
        exp_valid = 1'b0;
        exp_data = '0;
        scale_valid = 1'b0;
        scale_data = '0;
        scale_factor = '0;
        reset_window = 1'b1;
        timed_out = 1'b0;
        exp_full_seen = 1'b0;
        scale_full_seen = 1'b0;
        inf_seen = 0;
        zero_seen = 0;
        exp_errors = 0;
        scale_errors = 0;
        flag_errors = 0;
        unexpected_errors = 0;
        timeout_errors = 0;
        cover_errors = 0;
        repeat (16) @(posedge clock);
        arst_n <= 1'b1;
        repeat (4) @(posedge clock);       // outputs must stay quiet after release.
        reset_window <= 1'b0;

        run_phase(200, 60, 0, 0);          // exp alone.
        run_phase(200, 0, 60, 1);          // scale alone, zero exponents.
        run_phase(150, 50, 60, 2);         // overflow and underflow.
        run_phase(400, 70, 70, 0);         // both peers on the multiplier.
        run_phase(200, 100, 100, 1);       // bursts against full.
        repeat (10) @(posedge clock);

        if (!exp_full_seen || !scale_full_seen) begin
            $display("A full output never went high during the bursts");
            cover_errors++;
        end
        if (inf_seen == 0 || zero_seen == 0) begin
            $display("No infinity or no zero result was seen on scale");
            cover_errors++;
        end
        total_errors = exp_errors + scale_errors + flag_errors + unexpected_errors
                     + timeout_errors + cover_errors;
        $display("errors: exp %0d, scale %0d, flag %0d, unexpected %0d, timeout %0d, cover %0d",
                 exp_errors, scale_errors, flag_errors, unexpected_errors,
                 timeout_errors, cover_errors);
        if (total_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
logic/fp_pkg.sv
logic/mlt_if.sv
logic/fp_mlt.sv
logic/mlt_arbiter.sv
logic/fp_exp.sv
logic/fp_scale.sv
logic/fp_unit_top.sv
+incdir+dv
dv/fp_unit_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= fp_unit_tb
RTL_TOP   ?= fp_unit_top
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TESTS PASSED" $(LOG) || (echo "simulation ended without a verdict"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
